// File: aes_key_config.svh
`ifndef AES_KEY_CONFIG_SVH
`define AES_KEY_CONFIG_SVH

// schedule word and key widths
`define AES_WORD_W 32
`define AES_KEY_W 256

// rounds of the longest key
`define AES_MAX_ROUNDS 14

// schedule words per key length
`define AES_NW_128 44
`define AES_NW_256 60

// words in the cipher key
`define AES_NK_128 4
`define AES_NK_256 8

`endif

// File: aes_key_pkg.sv
`default_nettype none

`include "aes_key_config.svh"

package aes_key_pkg;

    typedef logic [`AES_WORD_W-1:0] word_t;
    typedef logic [4*`AES_WORD_W-1:0] round_key_t;   // four words, w0 in the top bits

    typedef logic key_len_t;
    localparam key_len_t KEY_128 = 1'b0;
    localparam key_len_t KEY_256 = 1'b1;

    typedef logic [5:0] word_idx_t;   // up to 59
    typedef logic [3:0] round_idx_t;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        LOAD   = 2'd1,
        EXPAND = 2'd2,
        DONE   = 2'd3
    } fsm_state_t;

endpackage

`default_nettype wire

// File: aes_gf_pkg.sv
`default_nettype none

`include "aes_key_config.svh"

package aes_gf_pkg;

    import aes_key_pkg::*;

    // multiply by x, reduce by x^8+x^4+x^3+x+1
    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] sh;
        acc = 8'h00;
        sh  = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i])
                acc = acc ^ sh;
            sh = xtime(sh);
        end
        return acc;
    endfunction

    // a^254, zero stays zero
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] r;
        logic [7:0] p;
        r = 8'h01;
        p = a;
        for (int i = 0; i < 7; i++) begin
            p = gf_mul(p, p);   // a^2, a^4 .. a^128
            r = gf_mul(r, p);
        end
        return r;
    endfunction

    function automatic logic [7:0] sbox_byte(input logic [7:0] a);
        logic [7:0] b;
        b = gf_inv(a);
        return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
                 ^ {b[3:0], b[7:4]} ^ 8'h63;   // affine map
    endfunction

    function automatic word_t sub_word(input word_t w);
        word_t s;
        for (int i = 0; i < 4; i++)
            s[8*i +: 8] = sbox_byte(w[8*i +: 8]);
        return s;
    endfunction

endpackage

`default_nettype wire

// File: key_expand_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_key_config.svh"

module key_expand_fsm
    import aes_key_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic init,
    input  logic last_word,
    output logic load,
    output logic expand_en,
    output logic done,
    output logic key_ready
);

    fsm_state_t state;
    fsm_state_t next_state;

    always_ff @(posedge clk) begin
        if (rst)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (init)
                    next_state = LOAD;
            end
            LOAD:   next_state = EXPAND;
            EXPAND: begin
                if (last_word)
                    next_state = DONE;
            end
            DONE:   next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    assign load      = (state == LOAD);
    assign expand_en = (state == EXPAND);
    assign done      = (state == DONE);

    // level, held until a new key is accepted
    always_ff @(posedge clk) begin
        if (rst)
            key_ready <= 1'b0;
        else if (state == IDLE && init)
            key_ready <= 1'b0;
        else if (state == DONE)
            key_ready <= 1'b1;
    end

endmodule

`default_nettype wire

// File: key_word_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_key_config.svh"

module key_word_counter
    import aes_key_pkg::*;
    import aes_gf_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      load,
    input  logic      expand_en,
    input  key_len_t  key_len,
    output word_idx_t word_idx,
    output key_len_t  key_len_q,
    output logic      last_word,
    output logic      key_phase,
    output logic      rot_step,
    output logic      sub_step,
    output logic [7:0] rcon
);

    logic [2:0] pos;   // index mod nk
    logic [2:0] pos_last;
    word_idx_t  nw_last;
    word_idx_t  nk;

    assign nk       = (key_len_q == KEY_256) ? word_idx_t'(`AES_NK_256) : word_idx_t'(`AES_NK_128);
    assign pos_last = (key_len_q == KEY_256) ? 3'(`AES_NK_256 - 1) : 3'(`AES_NK_128 - 1);
    assign nw_last  = (key_len_q == KEY_256) ? word_idx_t'(`AES_NW_256 - 1)
                                             : word_idx_t'(`AES_NW_128 - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            word_idx  <= '0;
            pos       <= '0;
            rcon      <= 8'h01;
            key_len_q <= KEY_128;
        end else if (load) begin
            word_idx  <= '0;
            pos       <= '0;
            rcon      <= 8'h01;
            key_len_q <= key_len;
        end else if (expand_en) begin
            word_idx <= word_idx + 1'b1;
            pos      <= (pos == pos_last) ? 3'd0 : pos + 1'b1;
            if (rot_step)
                rcon <= xtime(rcon);   // 01 02 04 .. 1b 36
        end
    end

    assign last_word = (word_idx == nw_last);
    assign key_phase = (word_idx < nk);
    assign rot_step  = !key_phase && (pos == 3'd0);
    assign sub_step  = !key_phase && (key_len_q == KEY_256) && (pos == 3'd4);

endmodule

`default_nettype wire

// File: key_word_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_key_config.svh"

module key_word_gen
    import aes_key_pkg::*;
    import aes_gf_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load,
    input  logic                  expand_en,
    input  logic [`AES_KEY_W-1:0] key_in,
    input  key_len_t              key_len,
    input  logic                  key_phase,
    input  logic                  rot_step,
    input  logic                  sub_step,
    input  logic [7:0]            rcon,
    output word_t                 word
);

    logic [`AES_KEY_W-1:0] key_q;   // unsent key words, next one on top
    key_len_t len_q;
    word_t    win [8];              // win[7] newest, win[0] eight back
    word_t    prev;
    word_t    back;
    word_t    rot;
    word_t    temp;

    always_ff @(posedge clk) begin
        if (rst)
            len_q <= KEY_128;
        else if (load)
            len_q <= key_len;
    end

    always_comb begin
        prev = win[7];
        back = (len_q == KEY_256) ? win[0] : win[4];   // w[i-nk]
        rot  = {prev[`AES_WORD_W-9:0], prev[`AES_WORD_W-1 -: 8]};
        if (rot_step)
            temp = sub_word(rot) ^ {rcon, {(`AES_WORD_W-8){1'b0}}};
        else if (sub_step)
            temp = sub_word(prev);
        else
            temp = prev;
        word = key_phase ? key_q[`AES_KEY_W-1 -: `AES_WORD_W] : (back ^ temp);
    end

    always_ff @(posedge clk) begin
        if (load) begin
            key_q <= key_in;
        end else if (expand_en) begin
            key_q <= key_q << `AES_WORD_W;
            for (int i = 0; i < 7; i++)
                win[i] <= win[i+1];
            win[7] <= word;
        end
    end

endmodule

`default_nettype wire

// File: round_key_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_key_config.svh"

module round_key_store
    import aes_key_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       wr_en,
    input  word_idx_t  word_idx,
    input  word_t      word,
    input  round_idx_t rd_round,
    input  logic       key_ready,
    output round_key_t round_key
);

    round_key_t mem [`AES_MAX_ROUNDS+1];
    round_idx_t wr_round;
    logic [1:0] wr_lane;
    logic [1:0] wr_slot;   // lane 0 sits in the top word

    assign wr_round = word_idx[5:2];
    assign wr_lane  = word_idx[1:0];
    assign wr_slot  = 2'd3 - wr_lane;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r <= `AES_MAX_ROUNDS; r++)
                mem[r] <= '0;
        end else if (wr_en) begin
            mem[wr_round][wr_slot * `AES_WORD_W +: `AES_WORD_W] <= word;
        end
    end

    // out of range rounds read as zero
    assign round_key = (key_ready && rd_round <= round_idx_t'(`AES_MAX_ROUNDS))
                       ? mem[rd_round] : '0;

endmodule

`default_nettype wire

// File: aes_key_expansion.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_key_config.svh"

module aes_key_expansion
    import aes_key_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`AES_KEY_W-1:0] key_in,   // 128-bit keys in the top half
    input  key_len_t              key_len,
    input  logic                  init,
    input  round_idx_t            round,
    output round_key_t            round_key,
    output logic                  key_ready,
    output round_idx_t            round_num
);

    logic       load;
    logic       expand_en;
    logic       done;
    logic       last_word;
    logic       key_phase;
    logic       rot_step;
    logic       sub_step;
    logic [7:0] rcon;
    word_idx_t  word_idx;
    key_len_t   key_len_q;
    word_t      word;

    key_expand_fsm u_fsm (
        .clk       (clk),
        .rst       (rst),
        .init      (init),
        .last_word (last_word),
        .load      (load),
        .expand_en (expand_en),
        .done      (done),
        .key_ready (key_ready)
    );

    key_word_counter u_counter (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .expand_en (expand_en),
        .key_len   (key_len),
        .word_idx  (word_idx),
        .key_len_q (key_len_q),
        .last_word (last_word),
        .key_phase (key_phase),
        .rot_step  (rot_step),
        .sub_step  (sub_step),
        .rcon      (rcon)
    );

    key_word_gen u_gen (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .expand_en (expand_en),
        .key_in    (key_in),
        .key_len   (key_len),
        .key_phase (key_phase),
        .rot_step  (rot_step),
        .sub_step  (sub_step),
        .rcon      (rcon),
        .word      (word)
    );

    round_key_store u_store (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (expand_en),
        .word_idx  (word_idx),
        .word      (word),
        .rd_round  (round),
        .key_ready (key_ready),
        .round_key (round_key)
    );

    // nw/4 - 1 rounds, 10 or 14
    assign round_num = (key_len_q == KEY_256) ? round_idx_t'(`AES_NW_256 / 4 - 1)
                                              : round_idx_t'(`AES_NW_128 / 4 - 1);

endmodule

`default_nettype wire

// File: aes_key_expansion_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_key_config.svh"

module aes_key_expansion_assert
    import aes_key_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      expand_en,
    input logic      key_ready,
    input logic      done,
    input logic      last_word,
    input word_idx_t word_idx,
    input key_len_t  key_len_q
);

    int        fail_count = 0;
    word_idx_t nw;

    assign nw = (key_len_q == KEY_256) ? word_idx_t'(`AES_NW_256) : word_idx_t'(`AES_NW_128);

    ready_low_in_expand: assert property (
        @(posedge clk) disable iff (rst) expand_en |-> !key_ready
    ) else begin
        $error("key_ready high while expanding");
        fail_count++;
    end

    index_in_range: assert property (
        @(posedge clk) disable iff (rst) expand_en |-> (word_idx < nw)
    ) else begin
        $error("word index past the schedule length");
        fail_count++;
    end

    // done only right after the last word
    done_after_last: assert property (
        @(posedge clk) disable iff (rst) done |-> $past(last_word)
    ) else begin
        $error("done without last_word in the cycle before");
        fail_count++;
    end

endmodule

bind aes_key_expansion aes_key_expansion_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .expand_en (expand_en),
    .key_ready (key_ready),
    .done      (done),
    .last_word (last_word),
    .word_idx  (word_idx),
    .key_len_q (key_len_q)
);

`default_nettype wire

// File: tb_aes_key_expansion.sv
`timescale 1ns/1ps
`default_nettype none

`include "aes_key_config.svh"

module tb_aes_key_expansion
    import aes_key_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int NUM_RANDOM = 16;
    localparam int NUM_KEYS = NUM_RANDOM + 3;   // two vectors, randoms, one after reset
    localparam int WATCHDOG_CYCLES = NUM_KEYS * 70 + 1000;
    localparam int READY_LIMIT = 100;
    localparam logic [7:0] AFFINE_C = 8'h63;

    logic                  clk;
    logic                  rst;
    logic [`AES_KEY_W-1:0] key_in;
    key_len_t              key_len;
    logic                  init;
    round_idx_t            round;
    round_key_t            round_key;
    logic                  key_ready;
    round_idx_t            round_num;

    int          errors;
    int          checks;
    bit          ready_expected;
    logic [31:0] model_w [60];   // reference schedule of the current key

    aes_key_expansion dut0 (
        .clk       (clk),
        .rst       (rst),
        .key_in    (key_in),
        .key_len   (key_len),
        .init      (init),
        .round     (round),
        .round_key (round_key),
        .key_ready (key_ready),
        .round_num (round_num)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [7:0] double_byte(input logic [7:0] a);
        return a[7] ? ((a << 1) ^ 8'h1b) : (a << 1);
    endfunction

    function automatic logic [7:0] field_product(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] p;
        x = a;
        y = b;
        p = 8'h00;
        while (y != 8'h00) begin
            if (y[0])
                p = p ^ x;
            x = double_byte(x);
            y = y >> 1;
        end
        return p;
    endfunction

    // search for the partner that gives one, zero has none
    function automatic logic [7:0] field_inverse(input logic [7:0] a);
        logic [7:0] inv;
        inv = 8'h00;
        for (int c = 1; c < 256; c++)
            if (field_product(a, 8'(c)) == 8'h01)
                inv = 8'(c);
        return inv;
    endfunction

    function automatic logic [7:0] sbox_model(input logic [7:0] a);
        logic [7:0] b;
        logic [7:0] s;
        b = field_inverse(a);
        for (int i = 0; i < 8; i++)
            s[i] = b[i] ^ b[(i+4)%8] ^ b[(i+5)%8] ^ b[(i+6)%8] ^ b[(i+7)%8] ^ AFFINE_C[i];
        return s;
    endfunction

    function automatic logic [31:0] subst_word(input logic [31:0] w);
        logic [31:0] s;
        for (int i = 0; i < 4; i++)
            s[8*i +: 8] = sbox_model(w[8*i +: 8]);
        return s;
    endfunction

    task automatic build_schedule(input logic [255:0] key, input key_len_t len);
        int          nk;
        int          nw;
        logic [31:0] temp;
        logic [7:0]  rc;
        nk = (len == KEY_256) ? `AES_NK_256 : `AES_NK_128;
        nw = (len == KEY_256) ? `AES_NW_256 : `AES_NW_128;
        rc = 8'h01;
        for (int i = 0; i < nw; i++) begin
            if (i < nk) begin
                model_w[i] = key[255 - 32*i -: 32];   // first word on top
            end else begin
                temp = model_w[i-1];
                if (i % nk == 0) begin
                    temp = subst_word({temp[23:0], temp[31:24]}) ^ {rc, 24'h000000};
                    rc = double_byte(rc);
                end else if (nk > 4 && i % nk == 4) begin
                    temp = subst_word(temp);
                end
                model_w[i] = model_w[i-nk] ^ temp;
            end
        end
    endtask

    function automatic round_key_t model_round(input int r);
        return {model_w[4*r], model_w[4*r+1], model_w[4*r+2], model_w[4*r+3]};
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1)
        else begin
            errors++;
            $display("%s", what);
        end
    endtask

    task automatic read_round(input int r, output round_key_t value);
        @(posedge clk);
        round <= round_idx_t'(r);
        @(negedge clk);
        value = round_key;
    endtask

    // one full key: init, wait for key_ready, read every round back
    task automatic run_key(input string name, input logic [255:0] key, input key_len_t len,
                           input bit stray);
        int         nw;
        int         nrounds;
        int         cycles;
        int         stray_at;
        round_key_t value;
        nw = (len == KEY_256) ? `AES_NW_256 : `AES_NW_128;
        nrounds = (len == KEY_256) ? 14 : 10;
        stray_at = stray ? 1 + int'($urandom % nw) : -1;
        build_schedule(key, len);
        @(posedge clk);
        key_in  <= key;
        key_len <= len;
        init    <= 1'b1;
        @(negedge clk);
        check_value({name, " key_ready before init"}, ready_expected, key_ready);
        @(posedge clk);   // init sampled here
        init <= 1'b0;
        @(negedge clk);
        check_value({name, " key_ready after init"}, 0, key_ready);
        cycles = 0;
        while (!key_ready && cycles < READY_LIMIT) begin
            @(posedge clk);
            cycles++;
            init <= (cycles == stray_at);   // init inside expand must be ignored
            @(negedge clk);
            if (!key_ready)
                check_value({name, " gated read"}, 0, round_key);
        end
        check_true(key_ready, $sformatf("%s: key_ready did not rise within %0d cycles",
                                        name, READY_LIMIT));
        check_value({name, " ready latency"}, nw + 2, cycles);
        check_value({name, " round_num"}, nrounds, round_num);
        for (int r = 0; r <= nrounds; r++) begin
            read_round(r, value);
            check_value($sformatf("%s round %0d", name, r), model_round(r), value);
        end
        ready_expected = 1'b1;
    endtask

    initial begin
        round_key_t   value;
        logic [255:0] key;
        key_len_t     len;
        rst = 1'b1;
        key_in = '0;
        key_len = KEY_128;
        init = 1'b0;
        round = '0;
        errors = 0;
        checks = 0;
        ready_expected = 1'b0;
        void'($urandom(32'hffc13cdc));
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset key_ready", 0, key_ready);
        check_value("reset round_key", 0, round_key);

        run_key("fips128", {128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h0}, KEY_128, 1'b0);
        read_round(10, value);
        check_value("fips128 round 10", 128'hd014f9a8c9ee2589e13f0cc8b6630ca6, value);
        check_value("fips128 round_num", 10, round_num);

        run_key("fips256",
                256'h603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4,
                KEY_256, 1'b0);
        read_round(14, value);
        check_value("fips256 round 14", 128'hfe4890d1e6188d0b046df344706c631e, value);
        check_value("fips256 round_num", 14, round_num);

        // lower half of a 128-bit key is random too and must not matter
        for (int k = 0; k < NUM_RANDOM; k++) begin
            key = {$urandom, $urandom, $urandom, $urandom,
                   $urandom, $urandom, $urandom, $urandom};
            len = key_len_t'($urandom % 2);
            run_key($sformatf("random %0d", k), key, len, bit'($urandom % 2));
        end

        @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        ready_expected = 1'b0;
        @(negedge clk);
        check_value("after reset key_ready", 0, key_ready);
        for (int r = 0; r <= `AES_MAX_ROUNDS; r++) begin
            read_round(r, value);
            check_value($sformatf("after reset round %0d", r), 0, value);
        end
        key = {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom};
        run_key("after reset", key, KEY_256, 1'b1);

        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut0.u_assert.fail_count);
        if (errors == 0 && dut0.u_assert.fail_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
aes_key_pkg.sv
aes_gf_pkg.sv
key_expand_fsm.sv
key_word_counter.sv
key_word_gen.sv
round_key_store.sv
aes_key_expansion.sv
aes_key_expansion_assert.sv
tb_aes_key_expansion.sv

// File: Bender.yml
package:
  name: aes_key_expansion

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - aes_key_pkg.sv
      - aes_gf_pkg.sv
      - key_expand_fsm.sv
      - key_word_counter.sv
      - key_word_gen.sv
      - round_key_store.sv
      - aes_key_expansion.sv
  - target: test
    include_dirs:
      - .
    files:
      - aes_key_expansion_assert.sv
      - tb_aes_key_expansion.sv
